/* tage_pkg.sv */
`default_nettype none

package tage_pkg;

	localparam int NUM_BANKS = 4;
	localparam int PC_WIDTH = 32;
	localparam int BANK_IDX_WIDTH = 8;
	localparam int TAG_WIDTH = 8;
	localparam int CTR_WIDTH = 3;
	localparam int U_WIDTH = 2;
	localparam int BASE_IDX_WIDTH = 10;
	localparam int BASE_CTR_WIDTH = 2;

	typedef struct packed {
		logic valid;
		logic [TAG_WIDTH-1:0] tag;
		logic [CTR_WIDTH-1:0] ctr;
	} bank_entry_t;

	typedef logic [U_WIDTH-1:0] u_t;
	typedef logic [BASE_CTR_WIDTH-1:0] base_ctr_t;

	// carried from lookup back to update untouched
	typedef struct packed {
		logic pred_taken;
		logic [NUM_BANKS-1:0] provider;
		logic [CTR_WIDTH-1:0] provider_ctr;
		u_t provider_u;
		base_ctr_t base_ctr;
		logic [NUM_BANKS-1:0] u_zero;
	} tage_meta_t;

	function automatic logic [BASE_IDX_WIDTH-1:0] base_index(input logic [PC_WIDTH-1:0] pc);
		return pc[BASE_IDX_WIDTH+1:2] ^ pc[PC_WIDTH-1 -: BASE_IDX_WIDTH];
	endfunction

	function automatic logic [BANK_IDX_WIDTH-1:0] bank_index(input logic [PC_WIDTH-1:0] pc,
			input int unsigned bank, input logic [BANK_IDX_WIDTH-1:0] fold_idx);
		return pc[BANK_IDX_WIDTH+1:2] ^ pc[10 + bank +: BANK_IDX_WIDTH] ^ fold_idx;
	endfunction

	// folded index rotated left by one
	function automatic logic [TAG_WIDTH-1:0] bank_tag(input logic [PC_WIDTH-1:0] pc,
			input logic [BANK_IDX_WIDTH-1:0] fold_idx, input logic [TAG_WIDTH-1:0] fold_tag);
		return pc[10 +: TAG_WIDTH] ^ fold_tag ^
			{fold_idx[BANK_IDX_WIDTH-2:0], fold_idx[BANK_IDX_WIDTH-1]};
	endfunction

	// width selects the saturation point, up to CTR_WIDTH bits
	function automatic logic [CTR_WIDTH-1:0] sat_update(input logic [CTR_WIDTH-1:0] value,
			input int unsigned width, input logic dir);
		logic [CTR_WIDTH-1:0] max_value;
		max_value = CTR_WIDTH'((1 << width) - 1);
		if (dir && value != max_value)
			return value + CTR_WIDTH'(1);
		if (!dir && value != '0)
			return value - CTR_WIDTH'(1);
		return value;
	endfunction

endpackage

`default_nettype wire

/* table_write_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface table_write_if;
	import tage_pkg::*;

	logic entry_we;
	logic [CTR_WIDTH-1:0] entry_ctr;
	logic u_we;
	u_t u_value;

	modport update (
		output entry_we, entry_ctr, u_we, u_value
	);

	modport bank (
		input entry_we, entry_ctr, u_we, u_value
	);

endinterface

`default_nettype wire

/* pred_table.sv */
`timescale 1ns/1ps
`default_nettype none

module pred_table #(
	parameter type entry_t = logic,
	parameter int DEPTH = 256
) (
	input  logic clk,
	input  logic rst,
	input  logic re,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	input  logic we,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  entry_t wdata,
	output entry_t rdata
);

	entry_t mem [DEPTH];

	// read sees the old value on a same-address write
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			mem <= '{default: '0};
			rdata <= '0;
		end else begin
			if (we) begin
				mem[waddr] <= wdata;
			end
			// hold last read between lookups
			if (re) begin
				rdata <= mem[raddr];
			end
		end
	end

endmodule

`default_nettype wire

/* tage_base.sv */
`timescale 1ns/1ps
`default_nettype none

module tage_base (
	input  logic clk,
	input  logic rst,
	input  logic lookup_valid,
	input  logic [tage_pkg::PC_WIDTH-1:0] lookup_pc,
	input  logic [tage_pkg::PC_WIDTH-1:0] update_pc,
	input  logic base_we,
	input  tage_pkg::base_ctr_t base_ctr_new,
	output tage_pkg::base_ctr_t base_ctr
);
	import tage_pkg::*;

	logic [BASE_IDX_WIDTH-1:0] lookup_idx;
	logic [BASE_IDX_WIDTH-1:0] update_idx;

	assign lookup_idx = base_index(lookup_pc);
	assign update_idx = base_index(update_pc);

	pred_table #(
		.entry_t(base_ctr_t),
		.DEPTH(2 ** BASE_IDX_WIDTH)
	) base_table (
		.clk(clk),
		.rst(rst),
		.re(lookup_valid),
		.raddr(lookup_idx),
		.we(base_we),
		.waddr(update_idx),
		.wdata(base_ctr_new),
		.rdata(base_ctr)
	);

endmodule

`default_nettype wire

/* tage_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module tage_bank #(
	parameter int BANK_ID = 0
) (
	input  logic clk,
	input  logic rst,
	input  logic lookup_valid,
	input  logic [tage_pkg::PC_WIDTH-1:0] lookup_pc,
	input  logic [tage_pkg::BANK_IDX_WIDTH-1:0] lookup_fold_idx,
	input  logic [tage_pkg::TAG_WIDTH-1:0] lookup_fold_tag,
	input  logic [tage_pkg::PC_WIDTH-1:0] update_pc,
	input  logic [tage_pkg::BANK_IDX_WIDTH-1:0] update_fold_idx,
	input  logic [tage_pkg::TAG_WIDTH-1:0] update_fold_tag,
	table_write_if.bank wr,
	output logic hit,
	output logic [tage_pkg::CTR_WIDTH-1:0] ctr,
	output tage_pkg::u_t u
);
	import tage_pkg::*;

	logic [BANK_IDX_WIDTH-1:0] lookup_idx;
	logic [BANK_IDX_WIDTH-1:0] update_idx;
	logic [TAG_WIDTH-1:0] lookup_tag;
	logic [TAG_WIDTH-1:0] update_tag;
	logic [TAG_WIDTH-1:0] lookup_tag_q;
	bank_entry_t entry_wdata;
	bank_entry_t entry_rdata;

	assign lookup_idx = bank_index(lookup_pc, BANK_ID, lookup_fold_idx);
	assign lookup_tag = bank_tag(lookup_pc, lookup_fold_idx, lookup_fold_tag);
	assign update_idx = bank_index(update_pc, BANK_ID, update_fold_idx);
	assign update_tag = bank_tag(update_pc, update_fold_idx, update_fold_tag);

	// tag lines up with the registered table read
	always_ff @(posedge clk) begin
		if (lookup_valid) begin
			lookup_tag_q <= lookup_tag;
		end
	end

	assign entry_wdata = '{valid: 1'b1, tag: update_tag, ctr: wr.entry_ctr};

	pred_table #(.entry_t(bank_entry_t), .DEPTH(2 ** BANK_IDX_WIDTH)) entry_table (
		.clk(clk), .rst(rst),
		.re(lookup_valid), .raddr(lookup_idx),
		.we(wr.entry_we), .waddr(update_idx), .wdata(entry_wdata),
		.rdata(entry_rdata)
	);

	pred_table #(.entry_t(u_t), .DEPTH(2 ** BANK_IDX_WIDTH)) u_table (
		.clk(clk), .rst(rst),
		.re(lookup_valid), .raddr(lookup_idx),
		.we(wr.u_we), .waddr(update_idx), .wdata(wr.u_value),
		.rdata(u)
	);

	assign hit = entry_rdata.valid && (entry_rdata.tag == lookup_tag_q);
	assign ctr = entry_rdata.ctr;

endmodule

`default_nettype wire

/* tage_select.sv */
`timescale 1ns/1ps
`default_nettype none

module tage_select (
	input  logic clk,
	input  logic rst,
	input  logic lookup_valid,
	input  logic [tage_pkg::NUM_BANKS-1:0] hits,
	input  logic [tage_pkg::NUM_BANKS-1:0][tage_pkg::CTR_WIDTH-1:0] ctrs,
	input  tage_pkg::u_t [tage_pkg::NUM_BANKS-1:0] us,
	input  tage_pkg::base_ctr_t base_ctr,
	output logic pred_valid,
	output logic pred_taken,
	output tage_pkg::tage_meta_t pred_meta
);
	import tage_pkg::*;

	logic [NUM_BANKS-1:0] provider;
	logic [CTR_WIDTH-1:0] provider_ctr;
	u_t provider_u;
	logic [NUM_BANKS-1:0] u_zero;

	// later banks override, so the highest hit wins
	always_comb begin
		provider = '0;
		provider_ctr = '0;
		provider_u = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			u_zero[i] = (us[i] == '0);
			if (hits[i]) begin
				provider = '0;
				provider[i] = 1'b1;
				provider_ctr = ctrs[i];
				provider_u = us[i];
			end
		end
	end

	assign pred_taken = (|hits) ? provider_ctr[CTR_WIDTH-1] : base_ctr[BASE_CTR_WIDTH-1];

	assign pred_meta = '{pred_taken: pred_taken, provider: provider,
		provider_ctr: provider_ctr, provider_u: provider_u,
		base_ctr: base_ctr, u_zero: u_zero};

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pred_valid <= 1'b0;
		end else begin
			pred_valid <= lookup_valid;
		end
	end

endmodule

`default_nettype wire

/* tage_update.sv */
`timescale 1ns/1ps
`default_nettype none

module tage_update (
	input  logic update_valid,
	input  logic update_taken,
	input  tage_pkg::tage_meta_t update_meta,
	output logic base_we,
	output tage_pkg::base_ctr_t base_ctr_new,
	table_write_if.update wr [tage_pkg::NUM_BANKS]
);
	import tage_pkg::*;

	logic has_provider;
	logic mispredict;
	logic disagree;
	logic [CTR_WIDTH-1:0] provider_ctr_new;
	logic [CTR_WIDTH-1:0] alloc_ctr;
	u_t provider_u_new;
	logic [NUM_BANKS-1:0] above;
	logic [NUM_BANKS-1:0] candidates;
	logic [NUM_BANKS-1:0] free;
	logic [NUM_BANKS-1:0] alloc;
	logic [NUM_BANKS-1:0] decay;
	logic [NUM_BANKS-1:0] u_train;

	assign has_provider = |update_meta.provider;
	assign mispredict = update_meta.pred_taken ^ update_taken;
	assign disagree = has_provider &&
		(update_meta.pred_taken != update_meta.base_ctr[BASE_CTR_WIDTH-1]);

	// base trains only when no bank provided
	assign base_we = update_valid && !has_provider;
	assign base_ctr_new = BASE_CTR_WIDTH'(sat_update(CTR_WIDTH'(update_meta.base_ctr),
		BASE_CTR_WIDTH, update_taken));

	assign provider_ctr_new = sat_update(update_meta.provider_ctr, CTR_WIDTH, update_taken);
	assign provider_u_new = U_WIDTH'(sat_update(CTR_WIDTH'(update_meta.provider_u),
		U_WIDTH, !mispredict));

	// weak taken or weak not taken
	assign alloc_ctr = update_taken ? CTR_WIDTH'(1 << (CTR_WIDTH - 1)) :
		CTR_WIDTH'((1 << (CTR_WIDTH - 1)) - 1);

	// banks strictly above the provider
	always_comb begin
		above = '0;
		for (int i = 1; i < NUM_BANKS; i++) begin
			above[i] = above[i-1] | update_meta.provider[i-1];
		end
	end

	assign candidates = has_provider ? above : '1;
	assign free = candidates & update_meta.u_zero & {NUM_BANKS{mispredict}};
	// lowest free candidate
	assign alloc = free & (~free + NUM_BANKS'(1));
	assign decay = candidates & {NUM_BANKS{mispredict && (free == '0)}};
	assign u_train = update_meta.provider & {NUM_BANKS{disagree}};

	for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_wr
		assign wr[i].entry_we = update_valid && (update_meta.provider[i] || alloc[i]);
		assign wr[i].entry_ctr = alloc[i] ? alloc_ctr : provider_ctr_new;
		assign wr[i].u_we = update_valid && (u_train[i] || alloc[i] || decay[i]);
		assign wr[i].u_value = u_train[i] ? provider_u_new : '0;
	end

endmodule

`default_nettype wire

/* tage_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tage_predictor (
	input  logic clk,
	input  logic rst,
	input  logic lookup_valid,
	input  logic [tage_pkg::PC_WIDTH-1:0] lookup_pc,
	input  logic [tage_pkg::NUM_BANKS-1:0][tage_pkg::BANK_IDX_WIDTH-1:0] lookup_fold_idx,
	input  logic [tage_pkg::NUM_BANKS-1:0][tage_pkg::TAG_WIDTH-1:0] lookup_fold_tag,
	input  logic update_valid,
	input  logic [tage_pkg::PC_WIDTH-1:0] update_pc,
	input  logic [tage_pkg::NUM_BANKS-1:0][tage_pkg::BANK_IDX_WIDTH-1:0] update_fold_idx,
	input  logic [tage_pkg::NUM_BANKS-1:0][tage_pkg::TAG_WIDTH-1:0] update_fold_tag,
	input  logic update_taken,
	input  tage_pkg::tage_meta_t update_meta,
	output logic pred_valid,
	output logic pred_taken,
	output tage_pkg::tage_meta_t pred_meta
);
	import tage_pkg::*;

	base_ctr_t base_ctr;
	base_ctr_t base_ctr_new;
	logic base_we;
	logic [NUM_BANKS-1:0] hits;
	logic [NUM_BANKS-1:0][CTR_WIDTH-1:0] ctrs;
	u_t [NUM_BANKS-1:0] us;

	table_write_if bank_wr [NUM_BANKS] ();

	tage_base base (
		.clk(clk), .rst(rst),
		.lookup_valid(lookup_valid), .lookup_pc(lookup_pc),
		.update_pc(update_pc), .base_we(base_we), .base_ctr_new(base_ctr_new),
		.base_ctr(base_ctr)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
		tage_bank #(.BANK_ID(i)) bank (
			.clk(clk), .rst(rst),
			.lookup_valid(lookup_valid), .lookup_pc(lookup_pc),
			.lookup_fold_idx(lookup_fold_idx[i]), .lookup_fold_tag(lookup_fold_tag[i]),
			.update_pc(update_pc),
			.update_fold_idx(update_fold_idx[i]), .update_fold_tag(update_fold_tag[i]),
			.wr(bank_wr[i]),
			.hit(hits[i]), .ctr(ctrs[i]), .u(us[i])
		);
	end

	tage_select select (
		.clk(clk), .rst(rst), .lookup_valid(lookup_valid),
		.hits(hits), .ctrs(ctrs), .us(us), .base_ctr(base_ctr),
		.pred_valid(pred_valid), .pred_taken(pred_taken), .pred_meta(pred_meta)
	);

	tage_update update (
		.update_valid(update_valid), .update_taken(update_taken),
		.update_meta(update_meta),
		.base_we(base_we), .base_ctr_new(base_ctr_new),
		.wr(bank_wr)
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end

endmodule

`default_nettype wire

/* tage_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module tage_sva (
	input logic clk,
	input logic rst,
	input logic lookup_valid,
	input logic pred_valid,
	input logic pred_taken,
	input tage_pkg::tage_meta_t pred_meta
);
	import tage_pkg::*;

	int unsigned fail_count = 0;

	valid_follows_lookup: assert property (@(posedge clk) disable iff (!rst)
		pred_valid == $past(lookup_valid))
	else begin
		fail_count++;
		$error("pred_valid does not follow lookup_valid by one cycle");
	end

	provider_onehot: assert property (@(posedge clk) disable iff (!rst)
		$onehot0(pred_meta.provider))
	else begin
		fail_count++;
		$error("provider is neither one-hot nor zero");
	end

	// base table decides when no bank hits
	base_decides: assert property (@(posedge clk) disable iff (!rst)
		(pred_valid && pred_meta.provider == '0) |->
		pred_taken == pred_meta.base_ctr[BASE_CTR_WIDTH-1])
	else begin
		fail_count++;
		$error("prediction without provider differs from base counter");
	end

endmodule

bind tage_predictor tage_sva sva_inst (
	.clk(clk),
	.rst(rst),
	.lookup_valid(lookup_valid),
	.pred_valid(pred_valid),
	.pred_taken(pred_taken),
	.pred_meta(pred_meta)
);

`default_nettype wire

/* tb_tage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tage;
	import tage_pkg::*;

	typedef logic [NUM_BANKS-1:0][BANK_IDX_WIDTH-1:0] fold_idx_t;
	typedef logic [NUM_BANKS-1:0][TAG_WIDTH-1:0] fold_tag_t;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_ITERS = 150;
	localparam int DIRECTED_OPS = 1 + 2 + 30 + 23;
	localparam int RANDOM_OPS = 2 * RANDOM_ITERS;
	localparam int WATCHDOG_NS = (DIRECTED_OPS + RANDOM_OPS) * 3 * CLK_PERIOD * 2 +
		RESET_CYCLES * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'h89f4752c;
	localparam logic [TAG_WIDTH-1:0] OTHER_KEY = 8'h3c;

	logic clk;
	logic rst;
	logic lookup_valid;
	logic [PC_WIDTH-1:0] lookup_pc;
	fold_idx_t lookup_fold_idx;
	fold_tag_t lookup_fold_tag;
	logic update_valid;
	logic [PC_WIDTH-1:0] update_pc;
	fold_idx_t update_fold_idx;
	fold_tag_t update_fold_tag;
	logic update_taken;
	tage_meta_t update_meta;
	logic pred_valid;
	logic pred_taken;
	tage_meta_t pred_meta;

	int errors = 0;
	int checks = 0;

	// reference copies of the three tables
	base_ctr_t base_mem [2 ** BASE_IDX_WIDTH];
	bank_entry_t entry_mem [NUM_BANKS][2 ** BANK_IDX_WIDTH];
	u_t u_mem [NUM_BANKS][2 ** BANK_IDX_WIDTH];

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen (
		.clk(clk),
		.rst(rst)
	);

	tage_predictor tage_predictor_inst (.*);

	function automatic logic [BASE_IDX_WIDTH-1:0] base_slot(input logic [31:0] pc);
		logic [31:0] mixed;
		mixed = (pc >> 2) ^ (pc >> 22);
		return mixed[BASE_IDX_WIDTH-1:0];
	endfunction

	function automatic logic [BANK_IDX_WIDTH-1:0] bank_slot(input logic [31:0] pc,
			input int bank, input logic [BANK_IDX_WIDTH-1:0] fidx);
		logic [31:0] mixed;
		mixed = (pc >> 2) ^ (pc >> (10 + bank)) ^ {24'h0, fidx};
		return mixed[BANK_IDX_WIDTH-1:0];
	endfunction

	function automatic logic [TAG_WIDTH-1:0] bank_key(input logic [31:0] pc,
			input logic [BANK_IDX_WIDTH-1:0] fidx, input logic [TAG_WIDTH-1:0] ftag);
		logic [31:0] shifted;
		logic [TAG_WIDTH-1:0] rotated;
		shifted = pc >> 10;
		rotated = (fidx << 1) | (fidx >> 7);
		return shifted[TAG_WIDTH-1:0] ^ ftag ^ rotated;
	endfunction

	function automatic int step_counter(input int value, input int max_value, input logic up);
		if (up)
			return (value < max_value) ? value + 1 : value;
		return (value > 0) ? value - 1 : value;
	endfunction

	function automatic tage_meta_t predict(input logic [31:0] pc, input fold_idx_t fidx,
			input fold_tag_t ftag);
		tage_meta_t m;
		bank_entry_t e;
		logic [BANK_IDX_WIDTH-1:0] slot;
		m = '0;
		m.base_ctr = base_mem[base_slot(pc)];
		for (int i = 0; i < NUM_BANKS; i++) begin
			slot = bank_slot(pc, i, fidx[i]);
			e = entry_mem[i][slot];
			m.u_zero[i] = (u_mem[i][slot] == '0);
			if (e.valid && e.tag == bank_key(pc, fidx[i], ftag[i])) begin
				m.provider = '0;
				m.provider[i] = 1'b1;
				m.provider_ctr = e.ctr;
				m.provider_u = u_mem[i][slot];
			end
		end
		m.pred_taken = (m.provider != '0) ? m.provider_ctr[CTR_WIDTH-1] :
			m.base_ctr[BASE_CTR_WIDTH-1];
		return m;
	endfunction

	function automatic void learn(input logic [31:0] pc, input fold_idx_t fidx,
			input fold_tag_t ftag, input logic taken, input tage_meta_t m);
		int prov;
		int first_free;
		logic wrong;
		logic [BANK_IDX_WIDTH-1:0] slot;
		prov = -1;
		first_free = -1;
		wrong = (m.pred_taken != taken);
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (m.provider[i])
				prov = i;
		end
		if (prov < 0) begin
			base_mem[base_slot(pc)] = base_ctr_t'(step_counter(m.base_ctr, 3, taken));
		end else begin
			slot = bank_slot(pc, prov, fidx[prov]);
			entry_mem[prov][slot].valid = 1'b1;
			entry_mem[prov][slot].tag = bank_key(pc, fidx[prov], ftag[prov]);
			entry_mem[prov][slot].ctr = CTR_WIDTH'(step_counter(m.provider_ctr, 7, taken));
			if (m.pred_taken != m.base_ctr[BASE_CTR_WIDTH-1])
				u_mem[prov][slot] = u_t'(step_counter(m.provider_u, 3, !wrong));
		end
		if (!wrong)
			return;
		for (int i = prov + 1; i < NUM_BANKS; i++) begin
			if (first_free < 0 && m.u_zero[i])
				first_free = i;
		end
		if (first_free >= 0) begin
			slot = bank_slot(pc, first_free, fidx[first_free]);
			entry_mem[first_free][slot].valid = 1'b1;
			entry_mem[first_free][slot].tag = bank_key(pc, fidx[first_free], ftag[first_free]);
			entry_mem[first_free][slot].ctr = taken ? CTR_WIDTH'(4) : CTR_WIDTH'(3);
			u_mem[first_free][slot] = '0;
		end else begin
			// nothing free, every candidate decays to zero
			for (int i = prov + 1; i < NUM_BANKS; i++)
				u_mem[i][bank_slot(pc, i, fidx[i])] = '0;
		end
	endfunction

	task automatic bit_check(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic ctr_check(input string what, input logic [CTR_WIDTH-1:0] got,
			input logic [CTR_WIDTH-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic meta_check(input string what, input tage_meta_t got, input tage_meta_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// called right after a falling edge, returns at the next one
	task automatic drive_cycle(input logic lk, input logic up, input logic [31:0] pc,
			input fold_idx_t fidx, input fold_tag_t ftag, input logic taken,
			input tage_meta_t meta, output logic got_taken, output tage_meta_t got_meta);
		lookup_valid = lk;
		lookup_pc = pc;
		lookup_fold_idx = fidx;
		lookup_fold_tag = ftag;
		update_valid = up;
		update_pc = pc;
		update_fold_idx = fidx;
		update_fold_tag = ftag;
		update_taken = taken;
		update_meta = meta;
		@(posedge clk);
		@(negedge clk);
		lookup_valid = 1'b0;
		update_valid = 1'b0;
		if (lk && pred_valid !== 1'b1) begin
			errors++;
			$display("no prediction appeared one cycle after the lookup at %0t", $time);
		end
		got_taken = pred_taken;
		got_meta = pred_meta;
	endtask

	task automatic lookup_and_compare(input logic [31:0] pc, input fold_idx_t fidx,
			input fold_tag_t ftag, output logic got_taken, output tage_meta_t got_meta);
		tage_meta_t exp;
		exp = predict(pc, fidx, ftag);
		drive_cycle(1'b1, 1'b0, pc, fidx, ftag, 1'b0, '0, got_taken, got_meta);
		bit_check("pred_taken", got_taken, exp.pred_taken);
		meta_check("pred_meta", got_meta, exp);
	endtask

	task automatic send_update(input logic [31:0] pc, input fold_idx_t fidx,
			input fold_tag_t ftag, input logic taken, input tage_meta_t meta);
		logic unused_taken;
		tage_meta_t unused_meta;
		drive_cycle(1'b0, 1'b1, pc, fidx, ftag, taken, meta, unused_taken, unused_meta);
		learn(pc, fidx, ftag, taken, meta);
	endtask

	// lookup in the same cycle as the update must see the old tables
	task automatic lookup_with_update(input logic [31:0] pc, input fold_idx_t fidx,
			input fold_tag_t ftag, input logic taken, input tage_meta_t meta);
		tage_meta_t exp;
		tage_meta_t got_meta;
		logic got_taken;
		exp = predict(pc, fidx, ftag);
		drive_cycle(1'b1, 1'b1, pc, fidx, ftag, taken, meta, got_taken, got_meta);
		learn(pc, fidx, ftag, taken, meta);
		bit_check("pred_taken", got_taken, exp.pred_taken);
		meta_check("pred_meta", got_meta, exp);
	endtask

	task automatic train_once(input logic [31:0] pc, input fold_idx_t fidx,
			input fold_tag_t ftag, input logic taken);
		tage_meta_t meta;
		logic got_taken;
		lookup_and_compare(pc, fidx, ftag, got_taken, meta);
		send_update(pc, fidx, ftag, taken, meta);
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("test %s finished with %0d errors", name, errors - start_errors);
	endtask

	task automatic reset_and_first_mispredict_test();
		logic [31:0] pc;
		tage_meta_t meta;
		logic got_taken;
		int start;
		start = errors;
		pc = 32'h0000_1040;
		bit_check("pred_valid", pred_valid, 1'b0);
		lookup_and_compare(pc, '0, '0, got_taken, meta);
		bit_check("pred_taken", got_taken, 1'b0);
		bit_check("provider_is_zero", meta.provider == '0, 1'b1);
		bit_check("base_ctr_is_zero", meta.base_ctr == '0, 1'b1);
		report_test("after_reset", start);
		start = errors;
		send_update(pc, '0, '0, 1'b1, meta);
		lookup_and_compare(pc, '0, '0, got_taken, meta);
		bit_check("provider_bank0", meta.provider == 4'b0001, 1'b1);
		ctr_check("provider_ctr", meta.provider_ctr, 3'd4);
		bit_check("base_ctr_is_one", meta.base_ctr == 2'd1, 1'b1);
		bit_check("pred_taken", got_taken, 1'b1);
		report_test("first_mispredict", start);
	endtask

	task automatic counter_saturation_test();
		logic [31:0] pc;
		tage_meta_t meta;
		logic got_taken;
		logic dir;
		int exp_ctr;
		int start;
		start = errors;
		pc = 32'h0004_2080;
		// climb allocations up to bank 3
		train_once(pc, '0, '0, 1'b1);
		train_once(pc, '0, '0, 1'b0);
		train_once(pc, '0, '0, 1'b1);
		train_once(pc, '0, '0, 1'b0);
		exp_ctr = 3;
		for (int n = 0; n < 11; n++) begin
			dir = (n < 6);
			lookup_and_compare(pc, '0, '0, got_taken, meta);
			bit_check("provider_bank3", meta.provider == 4'b1000, 1'b1);
			ctr_check("provider_ctr", meta.provider_ctr, CTR_WIDTH'(exp_ctr));
			bit_check("pred_taken", got_taken, exp_ctr >= 4);
			send_update(pc, '0, '0, dir, meta);
			exp_ctr = step_counter(exp_ctr, 7, dir);
		end
		report_test("counter_saturation", start);
	endtask

	task automatic usefulness_decay_test();
		logic [31:0] pc;
		fold_tag_t keys;
		tage_meta_t meta;
		logic got_taken;
		int start;
		start = errors;
		pc = 32'h0010_30c0;
		keys = '0;
		train_once(pc, '0, keys, 1'b1);
		train_once(pc, '0, keys, 1'b1);
		lookup_and_compare(pc, '0, keys, got_taken, meta);
		bit_check("provider_u_grew", meta.provider_u == 2'd1, 1'b1);
		send_update(pc, '0, keys, 1'b0, meta);
		train_once(pc, '0, keys, 1'b1);
		train_once(pc, '0, keys, 1'b1);
		// hide bank 2 so bank 1 provides and gains u
		keys[2] = OTHER_KEY;
		train_once(pc, '0, keys, 1'b1);
		keys[1] = OTHER_KEY;
		train_once(pc, '0, keys, 1'b0);
		keys = '0;
		train_once(pc, '0, keys, 1'b1);
		train_once(pc, '0, keys, 1'b1);
		keys = {OTHER_KEY, OTHER_KEY, OTHER_KEY, 8'h00};
		lookup_and_compare(pc, '0, keys, got_taken, meta);
		bit_check("provider_bank0", meta.provider == 4'b0001, 1'b1);
		bit_check("higher_banks_busy", meta.u_zero[3:1] == 3'b000, 1'b1);
		send_update(pc, '0, keys, !got_taken, meta);
		lookup_and_compare(pc, '0, keys, got_taken, meta);
		bit_check("higher_banks_decayed", meta.u_zero[3:1] == 3'b111, 1'b1);
		send_update(pc, '0, keys, !got_taken, meta);
		lookup_and_compare(pc, '0, keys, got_taken, meta);
		bit_check("allocated_bank1", meta.provider == 4'b0010, 1'b1);
		report_test("usefulness_decay", start);
	endtask

	task automatic random_traffic_test();
		logic [31:0] pool [6];
		logic [31:0] pc;
		fold_idx_t fidx;
		fold_tag_t ftag;
		tage_meta_t meta;
		logic got_taken;
		logic taken;
		int start;
		start = errors;
		foreach (pool[k])
			pool[k] = $urandom & 32'h00ff_fffc;
		for (int n = 0; n < RANDOM_ITERS; n++) begin
			pc = pool[$urandom % 6];
			for (int i = 0; i < NUM_BANKS; i++) begin
				fidx[i] = BANK_IDX_WIDTH'($urandom % 2);
				ftag[i] = ($urandom % 2) ? OTHER_KEY : 8'h00;
			end
			taken = $urandom % 2;
			lookup_and_compare(pc, fidx, ftag, got_taken, meta);
			if ($urandom % 4 == 0)
				lookup_with_update(pc, fidx, ftag, taken, meta);
			else
				send_update(pc, fidx, ftag, taken, meta);
		end
		report_test("random_traffic", start);
	endtask

	initial begin
		void'($urandom(SEED));
		lookup_valid = 1'b0;
		lookup_pc = '0;
		lookup_fold_idx = '0;
		lookup_fold_tag = '0;
		update_valid = 1'b0;
		update_pc = '0;
		update_fold_idx = '0;
		update_fold_tag = '0;
		update_taken = 1'b0;
		update_meta = '0;
		foreach (base_mem[a])
			base_mem[a] = '0;
		foreach (entry_mem[b, a]) begin
			entry_mem[b][a] = '0;
			u_mem[b][a] = '0;
		end
		@(posedge rst);
		@(negedge clk);
		reset_and_first_mispredict_test();
		counter_saturation_test();
		usefulness_decay_test();
		random_traffic_test();
		errors += tage_predictor_inst.sva_inst.fail_count;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
tage_pkg.sv
table_write_if.sv
pred_table.sv
tage_base.sv
tage_bank.sv
tage_select.sv
tage_update.sv
tage_predictor.sv
tb_clock.sv
tage_sva.sv
tb_tage.sv

/* Bender.yml */
package:
  name: tage_predictor

sources:
  - tage_pkg.sv
  - table_write_if.sv
  - pred_table.sv
  - tage_base.sv
  - tage_bank.sv
  - tage_select.sv
  - tage_update.sv
  - tage_predictor.sv
  - target: test
    files:
      - tb_clock.sv
      - tage_sva.sv
      - tb_tage.sv
